// File: compile.f
tlbPkg.sv
jointTlb.sv
tlbLookupArbiter.sv
instMicroTlb.sv
dataMicroTlb.sv
mmuTop.sv
mmuTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the MMU testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module mmuTb -o mmuSim

./obj_dir/mmuSim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"

// File: mmuTb.sv
// ******************************
// model assumes a flush after every entry write
// ******************************
`timescale 1ns/1ps

module mmuTb;
    import tlbPkg::*;

    localparam int TIMEOUT_CYCLES = 3000;   // six short tests need a few hundred
    localparam int STALL_LIMIT    = 10;

    logic       clk;
    logic       rstN;
    logic       flush;
    asidT       asid;
    cacheAttrT  k0Attr;
    logic       writeEn;
    logic [3:0] writeIndex;
    tlbEntryT   writeEntry;
    logic       fetchReq;
    vaddrT      fetchAddr;
    logic       load;
    logic       store;
    vaddrT      dataAddr;
    paddrT      instPhysAddr;
    logic       instCached;
    logic       instStall;
    excCodeT    instExc;
    paddrT      dataPhysAddr;
    logic       dataCached;
    logic       dataStall;
    excCodeT    dataExc;

    tlbEntryT    modelEntry [16];
    logic        modelValid [16];
    int          checks;
    int          errors;
    int          cycleCount;
    int          testErrStart;
    int          waited;
    logic [31:0] seedDummy;
    tlbEntryT    ent;
    logic [24:0] pageA;
    logic [24:0] pageB;

    mmuTop #(.tlbEntries(16)) u_mmuTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("run exceeded %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [24:0] makePage(pfnT pfn, cacheAttrT c, logic d, logic v);
        return {pfn, c, d, v};
    endfunction

    function automatic tlbEntryT makeEntry(vpn2T v, asidT a, logic g,
                                           logic [24:0] even, logic [24:0] odd);
        return {v, a, g, even, odd};
    endfunction

    function automatic logic [24:0] randPage();
        logic [31:0] r;
        r = $urandom;
        return makePage(r[19:0], r[22:20], 1'b1, 1'b1);
    endfunction

    // lowest valid slot whose vpn2 and asid (or global) match
    function automatic int findSlot(vpn2T v);
        int hit;
        hit = -1;
        for (int i = 15; i >= 0; i--) begin
            if (modelValid[i] && modelEntry[i][ENTRY_VPN2_LSB +: $bits(vpn2T)] == v
                && (modelEntry[i][ENTRY_G]
                    || modelEntry[i][ENTRY_ASID_LSB +: $bits(asidT)] == asid)) begin
                hit = i;
            end
        end
        return hit;
    endfunction

    task automatic expectAccess(input vaddrT addr, input logic isStore,
                                output paddrT pa, output logic cached, output excCodeT exc);
        int          slot;
        logic [24:0] page;
        pa     = '0;
        cached = 1'b0;
        exc    = excNone;
        if (addr[31:29] == 3'b100) begin
            pa     = addr - 32'h8000_0000;
            cached = (k0Attr == CACHE_ATTR_CACHED);
        end else if (addr[31:29] == 3'b101) begin
            pa = addr - 32'hA000_0000;
        end else begin
            slot = findSlot(addr[31:13]);
            if (slot < 0) begin
                exc = isStore ? excRefillStore : excRefillLoad;
            end else begin
                page   = addr[12] ? modelEntry[slot][ENTRY_V1 +: 25]
                                  : modelEntry[slot][ENTRY_V0 +: 25];
                pa     = {page[24:5], addr[11:0]};
                cached = (page[4:2] == CACHE_ATTR_CACHED);
                if (!page[0]) begin
                    exc = isStore ? excInvalidStore : excInvalidLoad;
                end else if (isStore && !page[1]) begin
                    exc = excModified;
                end
            end
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkSide(input logic isFetch, input logic isStore, input vaddrT addr);
        paddrT   pa;
        logic    cached;
        excCodeT exc;
        expectAccess(addr, isStore, pa, cached, exc);
        if (isFetch) begin
            checkValue("instExc", 32'(instExc), 32'(exc));
            if (exc == excNone) begin   // address only meaningful without a fault
                checkValue("instPhysAddr", instPhysAddr, pa);
                checkValue("instCached", 32'(instCached), 32'(cached));
            end
        end else begin
            checkValue("dataExc", 32'(dataExc), 32'(exc));
            if (exc == excNone || exc == excModified) begin
                checkValue("dataPhysAddr", dataPhysAddr, pa);
                checkValue("dataCached", 32'(dataCached), 32'(cached));
            end
        end
    endtask

    task automatic waitStalls(output int cycles);
        cycles = 0;
        #4;   // outputs have settled by mid-cycle
        while ((instStall || dataStall) && cycles <= STALL_LIMIT) begin
            @(posedge clk);
            #5;
            cycles++;
        end
        checks++;
        assert (cycles <= STALL_LIMIT) else begin
            $display("stall stayed high for more than %0d cycles", STALL_LIMIT);
            errors++;
        end
    endtask

    task automatic releaseInputs();
        @(posedge clk);
        #1;
        fetchReq = 1'b0;
        load     = 1'b0;
        store    = 1'b0;
    endtask

    task automatic runAccess(input logic isFetch, input logic isStore, input vaddrT addr,
                             output int cycles);
        if (isFetch) begin
            fetchReq  = 1'b1;
            fetchAddr = addr;
        end else begin
            load     = !isStore;
            store    = isStore;
            dataAddr = addr;
        end
        waitStalls(cycles);
        checkSide(isFetch, isStore, addr);
        releaseInputs();
    endtask

    task automatic runBoth(input vaddrT instAddr, input vaddrT dataAddrIn);
        int cycles;
        fetchReq  = 1'b1;
        fetchAddr = instAddr;
        load      = 1'b1;
        dataAddr  = dataAddrIn;
        waitStalls(cycles);
        checkSide(1'b1, 1'b0, instAddr);
        checkSide(1'b0, 1'b0, dataAddrIn);
        releaseInputs();
    endtask

    task automatic writeSlot(input logic [3:0] slot, input tlbEntryT e);
        writeEn    = 1'b1;
        writeIndex = slot;
        writeEntry = e;
        @(posedge clk);
        #1;
        writeEn          = 1'b0;
        modelEntry[slot] = e;
        modelValid[slot] = 1'b1;
    endtask

    task automatic pulseFlush();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic reportTest(input string name);
        $display("test %s: %s", name, (errors == testErrStart) ? "pass" : "fail");
        testErrStart = errors;
    endtask

    initial begin
        rstN       = 1'b0;
        flush      = 1'b0;
        asid       = 8'h05;
        k0Attr     = 3'd3;
        writeEn    = 1'b0;
        writeIndex = '0;
        writeEntry = '0;
        fetchReq   = 1'b0;
        fetchAddr  = '0;
        load       = 1'b0;
        store      = 1'b0;
        dataAddr   = '0;
        checks     = 0;
        errors     = 0;
        testErrStart = 0;
        for (int i = 0; i < 16; i++) begin
            modelValid[i] = 1'b0;
            modelEntry[i] = '0;
        end
        seedDummy = $urandom(22431);
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;

        runAccess(1'b1, 1'b0, 32'h8000_1234, waited);
        checkValue("instStall cycles", 32'(waited), 32'd0);
        runAccess(1'b0, 1'b0, 32'h9ABC_0010, waited);
        checkValue("dataStall cycles", 32'(waited), 32'd0);
        k0Attr = 3'd2;
        runAccess(1'b0, 1'b0, 32'h8000_0040, waited);
        checkValue("dataStall cycles", 32'(waited), 32'd0);
        runAccess(1'b1, 1'b0, 32'hA000_0100, waited);
        checkValue("instStall cycles", 32'(waited), 32'd0);
        runAccess(1'b0, 1'b1, 32'hBFFF_FFF0, waited);
        checkValue("dataStall cycles", 32'(waited), 32'd0);
        k0Attr = 3'd3;
        reportTest("fixedSegments");

        for (int i = 0; i < 4; i++) begin
            writeSlot(i[3:0], makeEntry(19'h00100 + i[18:0], asid, 1'b0,
                                        randPage(), randPage()));
        end
        pulseFlush();
        for (int i = 0; i < 4; i++) begin
            runAccess(1'b0, 1'b0, {19'h00100 + i[18:0], 1'b0, 12'hABC}, waited);
            runAccess(1'b1, 1'b0, {19'h00100 + i[18:0], 1'b1, 12'h3F0}, waited);
        end
        reportTest("mappedHits");

        pageA = makePage(20'h12345, 3'd2, 1'b0, 1'b1);   // valid but clean
        pageB = makePage(20'h0BEEF, 3'd3, 1'b1, 1'b1);   // valid and dirty
        writeSlot(4'd4, makeEntry(19'h00200, asid, 1'b0, 25'h0, pageA));
        writeSlot(4'd5, makeEntry(19'h00201, asid, 1'b0, pageB, pageA));
        pulseFlush();
        runAccess(1'b0, 1'b0, 32'hE000_0000, waited);
        runAccess(1'b0, 1'b1, 32'hE000_0000, waited);
        runAccess(1'b0, 1'b0, {19'h00200, 1'b0, 12'h010}, waited);
        runAccess(1'b0, 1'b1, {19'h00200, 1'b0, 12'h010}, waited);
        runAccess(1'b1, 1'b0, {19'h00200, 1'b0, 12'h020}, waited);
        runAccess(1'b0, 1'b1, {19'h00200, 1'b1, 12'h030}, waited);
        runAccess(1'b0, 1'b1, {19'h00201, 1'b0, 12'h040}, waited);
        reportTest("exceptions");

        writeSlot(4'd6, makeEntry(19'h00300, 8'h22, 1'b0, randPage(), randPage()));
        pulseFlush();
        runAccess(1'b0, 1'b0, {19'h00300, 1'b0, 12'h100}, waited);
        writeSlot(4'd6, makeEntry(19'h00300, 8'h22, 1'b1, randPage(), randPage()));
        pulseFlush();
        runAccess(1'b0, 1'b0, {19'h00300, 1'b0, 12'h100}, waited);
        reportTest("asidGlobal");

        writeSlot(4'd7, makeEntry(19'h00400, asid, 1'b0, randPage(), randPage()));
        writeSlot(4'd8, makeEntry(19'h00401, asid, 1'b0, randPage(), randPage()));
        pulseFlush();
        runBoth({19'h00400, 1'b1, 12'h204}, {19'h00401, 1'b0, 12'h308});
        reportTest("sharedLookup");

        ent = makeEntry(19'h00500, asid, 1'b0, randPage(), randPage());
        writeSlot(4'd9, ent);
        pulseFlush();
        runAccess(1'b0, 1'b0, {19'h00500, 1'b0, 12'h444}, waited);
        ent[ENTRY_PFN0_LSB] = ~ent[ENTRY_PFN0_LSB];   // new pfn for the even page
        writeSlot(4'd9, ent);
        pulseFlush();
        runAccess(1'b0, 1'b0, {19'h00500, 1'b0, 12'h444}, waited);
        reportTest("flush");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: mmuTop.sv
// ******************************
// pulse flush after any entry write or asid change
// ******************************
`timescale 1ns/1ps

module mmuTop import tlbPkg::*; #(
    parameter int tlbEntries = 16
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          flush,
    input  asidT                          asid,
    input  cacheAttrT                     k0Attr,
    input  logic                          writeEn,
    input  logic [$clog2(tlbEntries)-1:0] writeIndex,
    input  tlbEntryT                      writeEntry,
    input  logic                          fetchReq,
    input  vaddrT                         fetchAddr,
    input  logic                          load,
    input  logic                          store,
    input  vaddrT                         dataAddr,
    output paddrT                         instPhysAddr,
    output logic                          instCached,
    output logic                          instStall,
    output excCodeT                       instExc,
    output paddrT                         dataPhysAddr,
    output logic                          dataCached,
    output logic                          dataStall,
    output excCodeT                       dataExc
);

    logic     instLookupReq;
    logic     dataLookupReq;
    vpn2T     instLookupVpn2;
    vpn2T     dataLookupVpn2;
    vpn2T     lookupVpn2;
    logic     instGrant;
    logic     dataGrant;
    tlbEntryT lookupEntry;
    logic     lookupFound;

    jointTlb #(
        .tlbEntries(tlbEntries)
    ) u_jointTlb (
        .clk        (clk),
        .rstN       (rstN),
        .writeEn    (writeEn),
        .writeIndex (writeIndex),
        .writeEntry (writeEntry),
        .asid       (asid),
        .lookupVpn2 (lookupVpn2),
        .lookupEntry(lookupEntry),
        .lookupFound(lookupFound)
    );

    tlbLookupArbiter u_tlbLookupArbiter (
        .clk           (clk),
        .rstN          (rstN),
        .instLookupReq (instLookupReq),
        .instLookupVpn2(instLookupVpn2),
        .dataLookupReq (dataLookupReq),
        .dataLookupVpn2(dataLookupVpn2),
        .instGrant     (instGrant),
        .dataGrant     (dataGrant),
        .lookupVpn2    (lookupVpn2)
    );

    instMicroTlb u_instMicroTlb (
        .clk           (clk),
        .rstN          (rstN),
        .flush         (flush),
        .fetchReq      (fetchReq),
        .fetchAddr     (fetchAddr),
        .k0Attr        (k0Attr),
        .lookupEntry   (lookupEntry),
        .lookupFound   (lookupFound),
        .instGrant     (instGrant),
        .instPhysAddr  (instPhysAddr),
        .instCached    (instCached),
        .instStall     (instStall),
        .instExc       (instExc),
        .instLookupReq (instLookupReq),
        .instLookupVpn2(instLookupVpn2)
    );

    dataMicroTlb u_dataMicroTlb (
        .clk           (clk),
        .rstN          (rstN),
        .flush         (flush),
        .load          (load),
        .store         (store),
        .dataAddr      (dataAddr),
        .k0Attr        (k0Attr),
        .lookupEntry   (lookupEntry),
        .lookupFound   (lookupFound),
        .dataGrant     (dataGrant),
        .dataPhysAddr  (dataPhysAddr),
        .dataCached    (dataCached),
        .dataStall     (dataStall),
        .dataExc       (dataExc),
        .dataLookupReq (dataLookupReq),
        .dataLookupVpn2(dataLookupVpn2)
    );

endmodule

// File: dataMicroTlb.sv
// ******************************
// dataAddr must hold while dataStall is high
// ******************************
`timescale 1ns/1ps

module dataMicroTlb import tlbPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      flush,
    input  logic      load,
    input  logic      store,
    input  vaddrT     dataAddr,
    input  cacheAttrT k0Attr,
    input  tlbEntryT  lookupEntry,
    input  logic      lookupFound,
    input  logic      dataGrant,
    output paddrT     dataPhysAddr,
    output logic      dataCached,
    output logic      dataStall,
    output excCodeT   dataExc,
    output logic      dataLookupReq,
    output vpn2T      dataLookupVpn2
);

    searchStateT state;
    tlbEntryT    bufEntry;
    logic        bufValid;
    logic        bufFound;
    logic        access;
    logic        mapped;
    logic        kseg0;
    logic        kseg1;
    logic        bufHit;
    pfnT         pagePfn;
    cacheAttrT   pageAttr;
    logic        pageValid;
    logic        pageDirty;

    assign access = load || store;
    assign kseg0  = (dataAddr[31:29] == 3'b100);
    assign kseg1  = (dataAddr[31:29] == 3'b101);
    assign mapped = !kseg0 && !kseg1;
    assign bufHit = bufValid
        && (bufEntry[ENTRY_VPN2_LSB +: $bits(vpn2T)] == dataAddr[31:13]);

    assign pagePfn   = dataAddr[12] ? bufEntry[ENTRY_PFN1_LSB +: $bits(pfnT)]
                                    : bufEntry[ENTRY_PFN0_LSB +: $bits(pfnT)];
    assign pageAttr  = dataAddr[12] ? bufEntry[ENTRY_C1_LSB +: $bits(cacheAttrT)]
                                    : bufEntry[ENTRY_C0_LSB +: $bits(cacheAttrT)];
    assign pageValid = dataAddr[12] ? bufEntry[ENTRY_V1] : bufEntry[ENTRY_V0];
    assign pageDirty = dataAddr[12] ? bufEntry[ENTRY_D1] : bufEntry[ENTRY_D0];

    always_comb begin
        if (kseg0) begin
            dataPhysAddr = dataAddr - 32'h8000_0000;
            dataCached   = (k0Attr == CACHE_ATTR_CACHED);
        end else if (kseg1) begin
            dataPhysAddr = dataAddr - 32'hA000_0000;
            dataCached   = 1'b0;   // kseg1 never cached
        end else begin
            dataPhysAddr = {pagePfn, dataAddr[11:0]};
            dataCached   = (pageAttr == CACHE_ATTR_CACHED);
        end
    end

    assign dataStall = access && mapped && !bufHit;

    always_comb begin
        dataExc = excNone;
        if (access && mapped && bufHit) begin
            if (!bufFound) begin
                dataExc = store ? excRefillStore : excRefillLoad;
            end else if (!pageValid) begin
                dataExc = store ? excInvalidStore : excInvalidLoad;
            end else if (store && !pageDirty) begin
                dataExc = excModified;   // write to clean page
            end
        end
    end

    assign dataLookupReq  = (state == stateSearch);
    assign dataLookupVpn2 = dataAddr[31:13];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stateIdle;
        end else if (state == stateIdle && dataStall) begin
            state <= stateSearch;
        end else if (state == stateSearch && dataGrant) begin
            state <= stateIdle;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bufValid <= 1'b0;
            bufFound <= 1'b0;
        end else if (flush) begin
            bufValid <= 1'b0;
            bufFound <= 1'b0;
        end else if (dataLookupReq && dataGrant) begin
            bufValid <= 1'b1;
            bufFound <= lookupFound;
        end
    end

    always_ff @(posedge clk) begin
        if (dataLookupReq && dataGrant) begin
            bufEntry <= {dataLookupVpn2, lookupEntry[ENTRY_VPN2_LSB-1:0]};
        end
    end

endmodule

// File: instMicroTlb.sv
// ******************************
// fetchAddr must hold while instStall is high
// ******************************
`timescale 1ns/1ps

module instMicroTlb import tlbPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      flush,
    input  logic      fetchReq,
    input  vaddrT     fetchAddr,
    input  cacheAttrT k0Attr,
    input  tlbEntryT  lookupEntry,
    input  logic      lookupFound,
    input  logic      instGrant,
    output paddrT     instPhysAddr,
    output logic      instCached,
    output logic      instStall,
    output excCodeT   instExc,
    output logic      instLookupReq,
    output vpn2T      instLookupVpn2
);

    searchStateT state;
    tlbEntryT    bufEntry;
    logic        bufValid;
    logic        bufFound;
    logic        kseg0;
    logic        kseg1;
    logic        bufHit;
    pfnT         pagePfn;
    cacheAttrT   pageAttr;
    logic        pageValid;

    assign kseg0 = (fetchAddr[31:29] == 3'b100);
    assign kseg1 = (fetchAddr[31:29] == 3'b101);
    assign bufHit = bufValid
        && (bufEntry[ENTRY_VPN2_LSB +: $bits(vpn2T)] == fetchAddr[31:13]);

    // bit 12 picks even or odd page
    assign pagePfn   = fetchAddr[12] ? bufEntry[ENTRY_PFN1_LSB +: $bits(pfnT)]
                                     : bufEntry[ENTRY_PFN0_LSB +: $bits(pfnT)];
    assign pageAttr  = fetchAddr[12] ? bufEntry[ENTRY_C1_LSB +: $bits(cacheAttrT)]
                                     : bufEntry[ENTRY_C0_LSB +: $bits(cacheAttrT)];
    assign pageValid = fetchAddr[12] ? bufEntry[ENTRY_V1] : bufEntry[ENTRY_V0];

    always_comb begin
        if (kseg0) begin
            instPhysAddr = fetchAddr - 32'h8000_0000;
            instCached   = (k0Attr == CACHE_ATTR_CACHED);
        end else if (kseg1) begin
            instPhysAddr = fetchAddr - 32'hA000_0000;
            instCached   = 1'b0;
        end else begin
            instPhysAddr = {pagePfn, fetchAddr[11:0]};
            instCached   = (pageAttr == CACHE_ATTR_CACHED);
        end
    end

    assign instStall = fetchReq && !kseg0 && !kseg1 && !bufHit;

    always_comb begin
        instExc = excNone;
        if (fetchReq && !kseg0 && !kseg1 && bufHit) begin
            if (!bufFound) begin
                instExc = excRefillLoad;   // fetch uses load codes
            end else if (!pageValid) begin
                instExc = excInvalidLoad;
            end
        end
    end

    assign instLookupReq  = (state == stateSearch);
    assign instLookupVpn2 = fetchAddr[31:13];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stateIdle;
        end else if (state == stateIdle && instStall) begin
            state <= stateSearch;
        end else if (state == stateSearch && instGrant) begin
            state <= stateIdle;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bufValid <= 1'b0;
            bufFound <= 1'b0;
        end else if (flush) begin
            bufValid <= 1'b0;
            bufFound <= 1'b0;
        end else if (instLookupReq && instGrant) begin
            bufValid <= 1'b1;
            bufFound <= lookupFound;
        end
    end

    // vpn2 kept from the request so a miss still matches on retry
    always_ff @(posedge clk) begin
        if (instLookupReq && instGrant) begin
            bufEntry <= {instLookupVpn2, lookupEntry[ENTRY_VPN2_LSB-1:0]};
        end
    end

endmodule

// File: tlbLookupArbiter.sv
// ******************************
// grants are same-cycle; data wins first tie
// ******************************
`timescale 1ns/1ps

module tlbLookupArbiter import tlbPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic instLookupReq,
    input  vpn2T instLookupVpn2,
    input  logic dataLookupReq,
    input  vpn2T dataLookupVpn2,
    output logic instGrant,
    output logic dataGrant,
    output vpn2T lookupVpn2
);

    logic lastWasData;   // winner of the last grant

    assign dataGrant  = dataLookupReq && (!instLookupReq || !lastWasData);
    assign instGrant  = instLookupReq && (!dataLookupReq || lastWasData);
    assign lookupVpn2 = instGrant ? instLookupVpn2 : dataLookupVpn2;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lastWasData <= 1'b0;   // so data goes first
        end else if (instGrant || dataGrant) begin
            lastWasData <= dataGrant;
        end
    end

endmodule

// File: jointTlb.sv
// ******************************
// lowest matching slot wins; no duplicate check
// ******************************
`timescale 1ns/1ps

module jointTlb import tlbPkg::*; #(
    parameter int tlbEntries = 16
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          writeEn,
    input  logic [$clog2(tlbEntries)-1:0] writeIndex,
    input  tlbEntryT                      writeEntry,
    input  asidT                          asid,
    input  vpn2T                          lookupVpn2,
    output tlbEntryT                      lookupEntry,
    output logic                          lookupFound
);

    tlbEntryT                entryMem [tlbEntries];
    logic [tlbEntries-1:0]   slotValid;
    logic [tlbEntries-1:0]   slotMatch;

    always_ff @(posedge clk) begin
        if (writeEn) begin
            entryMem[writeIndex] <= writeEntry;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slotValid <= '0;
        end else if (writeEn) begin
            slotValid[writeIndex] <= 1'b1;
        end
    end

    // parallel compare across all slots
    always_comb begin
        for (int i = 0; i < tlbEntries; i++) begin
            slotMatch[i] = slotValid[i]
                && (entryMem[i][ENTRY_VPN2_LSB +: $bits(vpn2T)] == lookupVpn2)
                && (entryMem[i][ENTRY_G]
                    || (entryMem[i][ENTRY_ASID_LSB +: $bits(asidT)] == asid));
        end
    end

    // walk down so the lowest slot is taken last
    always_comb begin
        lookupFound = 1'b0;
        lookupEntry = '0;
        for (int i = tlbEntries - 1; i >= 0; i--) begin
            if (slotMatch[i]) begin
                lookupFound = 1'b1;
                lookupEntry = entryMem[i];
            end
        end
    end

endmodule

// File: tlbPkg.sv
// ******************************
// entry layout is fixed at 4 KB page pairs
// ******************************
package tlbPkg;

    typedef logic [31:0] vaddrT;
    typedef logic [31:0] paddrT;
    typedef logic [18:0] vpn2T;      // vaddr[31:13]
    typedef logic [19:0] pfnT;
    typedef logic [7:0]  asidT;
    typedef logic [2:0]  cacheAttrT;
    typedef logic [77:0] tlbEntryT;

    // tlbEntryT bit positions from the msb down
    localparam int ENTRY_VPN2_LSB = 59;
    localparam int ENTRY_ASID_LSB = 51;
    localparam int ENTRY_G        = 50;
    localparam int ENTRY_PFN0_LSB = 30;
    localparam int ENTRY_C0_LSB   = 27;
    localparam int ENTRY_D0       = 26;
    localparam int ENTRY_V0       = 25;
    localparam int ENTRY_PFN1_LSB = 5;
    localparam int ENTRY_C1_LSB   = 2;
    localparam int ENTRY_D1       = 1;
    localparam int ENTRY_V1       = 0;

    localparam cacheAttrT CACHE_ATTR_CACHED = 3'd3;

    typedef enum logic [2:0] {
        excNone,
        excRefillLoad,
        excRefillStore,
        excInvalidLoad,
        excInvalidStore,
        excModified
    } excCodeT;

    typedef enum logic {
        stateIdle,
        stateSearch
    } searchStateT;

endpackage
